/* design/bus_err_unit.sv */
// Memory bus error unit that queues the address and code of failed transactions
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module bus_err_unit import cl_periph_pkg::*; #(
  parameter int unsigned NUM_OUTSTANDING = 2,
  parameter int unsigned QUEUE_DEPTH     = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  mem_req_i,
  input  wire logic                  mem_gnt_i,
  input  wire logic [`CL_ADDR_W-1:0] mem_addr_i,
  input  wire logic                  mem_rvalid_i,
  input  wire logic [`CL_ERR_W-1:0]  mem_err_i,
  input  wire logic                  reg_valid_i,
  input  wire logic                  reg_write_i,
  input  wire logic [`CL_ADDR_W-1:0] reg_addr_i,
  output logic                       reg_ready_o,
  output logic [`CL_DATA_W-1:0]      reg_rdata_o,
  output logic                       err_irq_o
);

  localparam int unsigned OUT_PTR_W = (NUM_OUTSTANDING > 1) ? $clog2(NUM_OUTSTANDING) : 1;
  localparam int unsigned Q_PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned Q_CNT_W   = $clog2(QUEUE_DEPTH + 1);

  logic [`CL_ADDR_W-1:0] out_addr_q [NUM_OUTSTANDING];
  logic [OUT_PTR_W-1:0]  out_wr_q, out_rd_q;
  err_record_t           err_q [QUEUE_DEPTH];
  logic [Q_PTR_W-1:0]    err_wr_q, err_rd_q;
  logic [Q_CNT_W-1:0]    err_cnt_q;
  logic                  overflow_q;
  logic                  granted, fail, full, push, pop, reg_access, ctrl_write;
  err_record_t           head;
  logic [`CL_DATA_W-1:0] read_data;

  assign granted    = mem_req_i && mem_gnt_i;
  assign fail       = mem_rvalid_i && (mem_err_i != '0);
  assign full       = err_cnt_q == Q_CNT_W'(QUEUE_DEPTH);
  assign push       = fail && !full;
  assign reg_access = reg_valid_i && !reg_ready_o;
  assign ctrl_write = reg_access && reg_write_i && (reg_addr_i == `CL_ADDR_W'(8));
  assign pop        = ctrl_write && (err_cnt_q != '0);
  assign head       = err_q[err_rd_q];
  assign err_irq_o  = err_cnt_q != '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_wr_q    <= '0;
      out_rd_q    <= '0;
      err_wr_q    <= '0;
      err_rd_q    <= '0;
      err_cnt_q   <= '0;
      overflow_q  <= 1'b0;
      reg_ready_o <= 1'b0;
    end else begin
      reg_ready_o <= reg_access;
      if (granted) begin
        out_wr_q <= (out_wr_q == OUT_PTR_W'(NUM_OUTSTANDING - 1)) ? '0 : out_wr_q + 1'b1;
      end
      // Responses come back in grant order
      if (mem_rvalid_i) begin
        out_rd_q <= (out_rd_q == OUT_PTR_W'(NUM_OUTSTANDING - 1)) ? '0 : out_rd_q + 1'b1;
      end
      if (push) begin
        err_wr_q <= (err_wr_q == Q_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : err_wr_q + 1'b1;
      end
      if (pop) begin
        err_rd_q <= (err_rd_q == Q_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : err_rd_q + 1'b1;
      end
      if (push && !pop) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end else if (pop && !push) begin
        err_cnt_q <= err_cnt_q - 1'b1;
      end
      if (ctrl_write) begin
        overflow_q <= 1'b0;
      end
      // A drop in the same cycle as the clear still counts
      if (fail && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted) begin
      out_addr_q[out_wr_q] <= mem_addr_i;
    end
    if (push) begin
      err_q[err_wr_q] <= '{addr: out_addr_q[out_rd_q], code: mem_err_i};
    end
    if (reg_access) begin
      reg_rdata_o <= read_data;
    end
  end

  always_comb begin
    read_data = '0;
    case (reg_addr_i)
      `CL_ADDR_W'(0): read_data = `CL_DATA_W'(head.addr);
      `CL_ADDR_W'(4): read_data = `CL_DATA_W'(head.code);
      `CL_ADDR_W'(8): begin
        read_data[7:0] = 8'(err_cnt_q);
        read_data[8]   = overflow_q;
      end
      default: read_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/cl_periph_defs.svh */
// Core-local peripheral subsystem widths, counts and register address map
`ifndef CL_PERIPH_DEFS_SVH
`define CL_PERIPH_DEFS_SVH

`define CL_ADDR_W            32
`define CL_DATA_W            32
`define CL_ERR_W             2
`define CL_NUM_EXT_IRQ       16
`define CL_NUM_IRQ           48
`define CL_IRQ_ID_W          6

`define CL_PERIPH_BASE       32'h0020_0000
`define CL_IRQ_OFFSET        32'h0000_0000
`define CL_INSTR_ERR_OFFSET  32'h0000_1000
`define CL_DATA_ERR_OFFSET   32'h0000_2000
`define CL_SHADOW_ERR_OFFSET 32'h0000_3000
`define CL_REGION_SIZE       32'h0000_1000
`define CL_ERR_VALUE         32'hBADC_AB1E

`define CL_BUS_ERR_IRQ_BASE  18
`define CL_TIMER_IRQ_BASE    16
`define CL_EXT_IRQ_BASE      32
`endif

/* design/cl_periph_pkg.sv */
// Core-local peripheral package with the register targets, interrupt and error record types
`default_nettype none

`include "cl_periph_defs.svh"

package cl_periph_pkg;

  // Register bus targets, in address map order
  typedef enum logic [1:0] {
    TGT_IRQ        = 2'd0,
    TGT_INSTR_ERR  = 2'd1,
    TGT_DATA_ERR   = 2'd2,
    TGT_SHADOW_ERR = 2'd3
  } cl_target_e;

  typedef logic [7:0] irq_level_t;

  // Per-source interrupt configuration
  typedef struct packed {
    logic       en;
    irq_level_t level;
  } irq_cfg_t;

  // One failed memory transaction
  typedef struct packed {
    logic [`CL_ADDR_W-1:0] addr;
    logic [`CL_ERR_W-1:0]  code;
  } err_record_t;

endpackage

`default_nettype wire

/* design/cl_periph_top.sv */
// Core-local peripherals: register demux, three bus error units and the interrupt controller
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module cl_periph_top import cl_periph_pkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       reg_valid_i,
  input  wire logic                       reg_write_i,
  input  wire logic [`CL_ADDR_W-1:0]      reg_addr_i,
  input  wire logic [`CL_DATA_W-1:0]      reg_wdata_i,
  input  wire logic [`CL_DATA_W/8-1:0]    reg_wstrb_i,
  output logic                            reg_ready_o,
  output logic [`CL_DATA_W-1:0]           reg_rdata_o,
  output logic                            reg_error_o,
  input  wire logic                       instr_req_i,
  input  wire logic                       instr_gnt_i,
  input  wire logic [`CL_ADDR_W-1:0]      instr_addr_i,
  input  wire logic                       instr_rvalid_i,
  input  wire logic [`CL_ERR_W-1:0]       instr_err_i,
  input  wire logic                       data_req_i,
  input  wire logic                       data_gnt_i,
  input  wire logic [`CL_ADDR_W-1:0]      data_addr_i,
  input  wire logic                       data_rvalid_i,
  input  wire logic [`CL_ERR_W-1:0]       data_err_i,
  input  wire logic                       shadow_req_i,
  input  wire logic                       shadow_gnt_i,
  input  wire logic [`CL_ADDR_W-1:0]      shadow_addr_i,
  input  wire logic                       shadow_rvalid_i,
  input  wire logic [`CL_ERR_W-1:0]       shadow_err_i,
  input  wire logic [`CL_NUM_EXT_IRQ-1:0] irq_ext_i,
  input  wire logic [1:0]                 irq_timer_i,
  input  wire logic                       irq_ready_i,
  output logic                            irq_valid_o,
  output logic [`CL_IRQ_ID_W-1:0]         irq_id_o,
  output irq_level_t                      irq_level_o
);

  localparam int unsigned NUM_TGT = 2 ** $bits(cl_target_e);
  // Machine timer pending position in the standard interrupt layout
  localparam int unsigned MTIP_ID = 7;

  logic [NUM_TGT-1:0]                tgt_valid;
  logic                              tgt_write;
  logic [`CL_ADDR_W-1:0]             tgt_addr;
  logic [`CL_DATA_W-1:0]             tgt_wdata;
  logic [`CL_DATA_W/8-1:0]           tgt_wstrb;
  logic [NUM_TGT-1:0]                tgt_ready;
  logic [NUM_TGT-1:0][`CL_DATA_W-1:0] tgt_rdata;
  logic [NUM_TGT-1:0]                tgt_error;
  logic [2:0]                        bus_err_irq;
  logic [`CL_NUM_IRQ-1:0]            irq_src;

  // No target reports bus errors of its own
  assign tgt_error = '0;

  regbus_demux u_demux (
    .clk_i, .reset_i,
    .reg_valid_i, .reg_write_i, .reg_addr_i, .reg_wdata_i, .reg_wstrb_i,
    .reg_ready_o, .reg_rdata_o, .reg_error_o,
    .tgt_valid_o (tgt_valid), .tgt_write_o (tgt_write), .tgt_addr_o  (tgt_addr),
    .tgt_wdata_o (tgt_wdata), .tgt_wstrb_o (tgt_wstrb),
    .tgt_ready_i (tgt_ready), .tgt_rdata_i (tgt_rdata), .tgt_error_i (tgt_error)
  );

  bus_err_unit u_instr_err (
    .clk_i, .reset_i,
    .mem_req_i (instr_req_i), .mem_gnt_i (instr_gnt_i), .mem_addr_i (instr_addr_i),
    .mem_rvalid_i (instr_rvalid_i), .mem_err_i (instr_err_i),
    .reg_valid_i (tgt_valid[TGT_INSTR_ERR]), .reg_write_i (tgt_write),
    .reg_addr_i (tgt_addr), .reg_ready_o (tgt_ready[TGT_INSTR_ERR]),
    .reg_rdata_o (tgt_rdata[TGT_INSTR_ERR]), .err_irq_o (bus_err_irq[0])
  );

  bus_err_unit u_data_err (
    .clk_i, .reset_i,
    .mem_req_i (data_req_i), .mem_gnt_i (data_gnt_i), .mem_addr_i (data_addr_i),
    .mem_rvalid_i (data_rvalid_i), .mem_err_i (data_err_i),
    .reg_valid_i (tgt_valid[TGT_DATA_ERR]), .reg_write_i (tgt_write),
    .reg_addr_i (tgt_addr), .reg_ready_o (tgt_ready[TGT_DATA_ERR]),
    .reg_rdata_o (tgt_rdata[TGT_DATA_ERR]), .err_irq_o (bus_err_irq[1])
  );

  bus_err_unit u_shadow_err (
    .clk_i, .reset_i,
    .mem_req_i (shadow_req_i), .mem_gnt_i (shadow_gnt_i), .mem_addr_i (shadow_addr_i),
    .mem_rvalid_i (shadow_rvalid_i), .mem_err_i (shadow_err_i),
    .reg_valid_i (tgt_valid[TGT_SHADOW_ERR]), .reg_write_i (tgt_write),
    .reg_addr_i (tgt_addr), .reg_ready_o (tgt_ready[TGT_SHADOW_ERR]),
    .reg_rdata_o (tgt_rdata[TGT_SHADOW_ERR]), .err_irq_o (bus_err_irq[2])
  );

  // Source vector at the fixed interrupt ids
  always_comb begin
    irq_src = '0;
    irq_src[`CL_EXT_IRQ_BASE +: `CL_NUM_EXT_IRQ] = irq_ext_i;
    irq_src[`CL_BUS_ERR_IRQ_BASE +: 3] = bus_err_irq;
    irq_src[`CL_TIMER_IRQ_BASE +: 2] = irq_timer_i;
    irq_src[MTIP_ID] = irq_timer_i[0];
  end

  irq_ctrl u_irq_ctrl (
    .clk_i, .reset_i,
    .irq_src_i (irq_src),
    .reg_valid_i (tgt_valid[TGT_IRQ]), .reg_write_i (tgt_write), .reg_addr_i (tgt_addr),
    .reg_wdata_i (tgt_wdata), .reg_wstrb_i (tgt_wstrb),
    .reg_ready_o (tgt_ready[TGT_IRQ]), .reg_rdata_o (tgt_rdata[TGT_IRQ]),
    .irq_valid_o, .irq_id_o, .irq_level_o, .irq_ready_i
  );

endmodule

`default_nettype wire

/* design/irq_ctrl.sv */
// Level-based interrupt controller with per-source configuration and a core handshake
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module irq_ctrl import cl_periph_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic [`CL_NUM_IRQ-1:0]  irq_src_i,
  input  wire logic                    reg_valid_i,
  input  wire logic                    reg_write_i,
  input  wire logic [`CL_ADDR_W-1:0]   reg_addr_i,
  input  wire logic [`CL_DATA_W-1:0]   reg_wdata_i,
  input  wire logic [`CL_DATA_W/8-1:0] reg_wstrb_i,
  output logic                         reg_ready_o,
  output logic [`CL_DATA_W-1:0]        reg_rdata_o,
  output logic                         irq_valid_o,
  output logic [`CL_IRQ_ID_W-1:0]      irq_id_o,
  output irq_level_t                   irq_level_o,
  input  wire logic                    irq_ready_i
);

  irq_cfg_t                cfg_q [`CL_NUM_IRQ];
  logic [`CL_IRQ_ID_W-1:0] reg_id;
  logic                    reg_hit;
  logic                    reg_access;
  logic [`CL_DATA_W-1:0]   read_data;
  logic                    best_found;
  logic [`CL_IRQ_ID_W-1:0] best_id;
  irq_level_t              best_level;

  // One word per source id
  assign reg_id     = reg_addr_i[`CL_IRQ_ID_W+1:2];
  assign reg_hit    = (reg_addr_i[`CL_ADDR_W-1:`CL_IRQ_ID_W+2] == '0) &&
                      (reg_id < `CL_IRQ_ID_W'(`CL_NUM_IRQ));
  assign reg_access = reg_valid_i && !reg_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ready_o <= 1'b0;
      for (int i = 0; i < `CL_NUM_IRQ; i++) begin
        cfg_q[i] <= '0;
      end
    end else begin
      reg_ready_o <= reg_access;
      if (reg_access && reg_write_i && reg_hit) begin
        if (reg_wstrb_i[0]) begin
          cfg_q[reg_id].en <= reg_wdata_i[0];
        end
        if (reg_wstrb_i[1]) begin
          cfg_q[reg_id].level <= reg_wdata_i[15:8];
        end
      end
    end
  end

  always_comb begin
    read_data = '0;
    if (reg_hit) begin
      read_data[0]    = cfg_q[reg_id].en;
      read_data[1]    = irq_src_i[reg_id];
      read_data[15:8] = cfg_q[reg_id].level;
    end
  end

  // Highest level wins, later ids take ties
  always_comb begin
    best_found = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int i = 0; i < `CL_NUM_IRQ; i++) begin
      if (cfg_q[i].en && irq_src_i[i] && (cfg_q[i].level != '0) &&
          (cfg_q[i].level >= best_level)) begin
        best_found = 1'b1;
        best_id    = `CL_IRQ_ID_W'(i);
        best_level = cfg_q[i].level;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_valid_o <= 1'b0;
    end else if (irq_valid_o && irq_ready_i) begin
      irq_valid_o <= 1'b0;
    end else begin
      irq_valid_o <= best_found;
    end
  end

  always_ff @(posedge clk_i) begin
    irq_id_o    <= best_id;
    irq_level_o <= best_level;
    if (reg_access) begin
      reg_rdata_o <= read_data;
    end
  end

endmodule

`default_nettype wire

/* design/regbus_demux.sv */
// Register bus demux that decodes the peripheral map and answers unmapped accesses
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module regbus_demux import cl_periph_pkg::*; #(
  localparam int unsigned NUM_TGT = 2 ** $bits(cl_target_e)
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 reset_i,
  input  wire logic                                 reg_valid_i,
  input  wire logic                                 reg_write_i,
  input  wire logic [`CL_ADDR_W-1:0]                reg_addr_i,
  input  wire logic [`CL_DATA_W-1:0]                reg_wdata_i,
  input  wire logic [`CL_DATA_W/8-1:0]              reg_wstrb_i,
  output logic                                      reg_ready_o,
  output logic [`CL_DATA_W-1:0]                     reg_rdata_o,
  output logic                                      reg_error_o,
  output logic [NUM_TGT-1:0]                        tgt_valid_o,
  output logic                                      tgt_write_o,
  output logic [`CL_ADDR_W-1:0]                     tgt_addr_o,
  output logic [`CL_DATA_W-1:0]                     tgt_wdata_o,
  output logic [`CL_DATA_W/8-1:0]                   tgt_wstrb_o,
  input  wire logic [NUM_TGT-1:0]                   tgt_ready_i,
  input  wire logic [NUM_TGT-1:0][`CL_DATA_W-1:0]   tgt_rdata_i,
  input  wire logic [NUM_TGT-1:0]                   tgt_error_i
);

  logic [NUM_TGT-1:0] hit;
  cl_target_e         sel;
  logic               mapped;
  logic               err_ready_q;

  function automatic logic in_region(logic [`CL_ADDR_W-1:0] addr, cl_target_e t);
    logic [`CL_ADDR_W-1:0] base;
    case (t)
      TGT_IRQ:        base = `CL_PERIPH_BASE + `CL_IRQ_OFFSET;
      TGT_INSTR_ERR:  base = `CL_PERIPH_BASE + `CL_INSTR_ERR_OFFSET;
      TGT_DATA_ERR:   base = `CL_PERIPH_BASE + `CL_DATA_ERR_OFFSET;
      TGT_SHADOW_ERR: base = `CL_PERIPH_BASE + `CL_SHADOW_ERR_OFFSET;
    endcase
    return (addr >= base) && (addr < base + `CL_REGION_SIZE);
  endfunction

  always_comb begin
    hit = '0;
    sel = TGT_IRQ;
    for (int t = 0; t < NUM_TGT; t++) begin
      hit[t] = in_region(reg_addr_i, cl_target_e'(t));
      if (hit[t]) begin
        sel = cl_target_e'(t);
      end
    end
  end

  assign mapped      = |hit;
  assign tgt_valid_o = hit & {NUM_TGT{reg_valid_i}};
  assign tgt_write_o = reg_write_i;
  assign tgt_addr_o  = reg_addr_i & (`CL_REGION_SIZE - 1);
  assign tgt_wdata_o = reg_wdata_i;
  assign tgt_wstrb_o = reg_wstrb_i;

  // Error responder for addresses outside every region
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_ready_q <= 1'b0;
    end else begin
      err_ready_q <= reg_valid_i && !mapped && !err_ready_q;
    end
  end

  assign reg_ready_o = mapped ? tgt_ready_i[sel] : err_ready_q;
  assign reg_error_o = mapped ? tgt_error_i[sel] : err_ready_q;
  assign reg_rdata_o = mapped ? tgt_rdata_i[sel] : `CL_ERR_VALUE;

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/cl_periph_pkg.sv
design/regbus_demux.sv
design/bus_err_unit.sv
design/irq_ctrl.sv
design/cl_periph_top.sv
sim/cl_periph_asserts.sv
sim/cl_periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the peripheral testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps --top-module cl_periph_tb \
  -f project.f -o cl_periph_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/cl_periph_sim > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim/cl_periph_asserts.sv */
// Register bus protocol assertions bound into the demux
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module cl_periph_asserts (
  input wire logic                       clk_i,
  input wire logic                       reset_i,
  input wire logic                       reg_valid_i,
  input wire logic                       reg_write_i,
  input wire logic [`CL_ADDR_W-1:0]      reg_addr_i,
  input wire logic [`CL_DATA_W-1:0]      reg_wdata_i,
  input wire logic [`CL_DATA_W/8-1:0]    reg_wstrb_i,
  input wire logic                       reg_ready_o,
  input wire logic [3:0]                 tgt_valid_o
);

  // Requester holds everything until ready
  request_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_valid_i && !reg_ready_o |=> reg_valid_i && $stable(reg_write_i) &&
      $stable(reg_addr_i) && $stable(reg_wdata_i) && $stable(reg_wstrb_i))
    else $error("register request changed before ready");

  ready_falls: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_valid_i && reg_ready_o |=> !reg_ready_o)
    else $error("register ready stayed high after a transfer");

  one_target: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(tgt_valid_o))
    else $error("more than one target valid");

endmodule

bind regbus_demux cl_periph_asserts u_asserts (
  .clk_i, .reset_i, .reg_valid_i, .reg_write_i, .reg_addr_i,
  .reg_wdata_i, .reg_wstrb_i, .reg_ready_o, .tgt_valid_o
);

`default_nettype wire

/* sim/cl_periph_stimulus.txt */
// Peripheral testbench commands, six hex words per line: op a b c d e
// 1 write b to a   2 read a, expect data b and error c   3 random write to a
// 4 bus a: d failures from address b upwards, code c   5 bus a: grants b, d with codes c, e
// 6 ext lines a, timer lines b   7 expect valid a, id b, level c   8 ack, expect id a
// 9 pop d records of region a from address b with code c   E end of test a
1 00200080 00000301 0 0 0
2 00200080 00000301 0 0 0
6 00000001 0 0 0 0
2 00200080 00000303 0 0 0
3 00204000 0 0 0 0
2 00204000 BADCAB1E 1 0 0
2 00200080 00000303 0 0 0
E 1 0 0 0 0
1 00200084 00000501 0 0 0
1 00200088 00000501 0 0 0
1 0020008C 00000900 0 0 0
1 00200090 00000001 0 0 0
6 0000001F 0 0 0 0
7 1 22 5 0 0
E 2 0 0 0 0
1 0020004C 00002001 0 0 0
4 1 80001000 2 1 0
7 1 13 20 0 0
2 00202000 80001000 0 0 0
2 00202004 00000002 0 0 0
2 00202008 00000001 0 0 0
1 00202008 0 0 0 0
2 00202008 00000000 0 0 0
7 1 22 5 0 0
E 3 0 0 0 0
5 2 80002000 0 80002004 3
2 00203008 00000001 0 0 0
2 00203000 80002004 0 0 0
2 00203004 00000003 0 0 0
1 00203008 0 0 0 0
E 4 0 0 0 0
4 0 80003000 1 9 0
2 00201008 00000108 0 0 0
9 00201000 80003000 1 8 0
2 00201008 00000000 0 0 0
E 5 0 0 0 0
7 1 22 5 0 0
8 22 0 0 0 0
6 0000001B 0 0 0 0
7 1 21 5 0 0
8 21 0 0 0 0
6 0 0 0 0 0
7 0 0 0 0 0
E 6 0 0 0 0

/* sim/cl_periph_tb.sv */
// Testbench for the core-local peripherals, run from a command file
`timescale 1ns/1ps
`default_nettype none

`include "cl_periph_defs.svh"

module cl_periph_tb;

  localparam int STIM_WORDS  = 512;
  localparam int REG_TIMEOUT = 16;
  localparam int IRQ_TIMEOUT = 16;

  logic                       clk;
  logic                       reset;
  logic                       reg_valid;
  logic                       reg_write;
  logic [`CL_ADDR_W-1:0]      reg_addr;
  logic [`CL_DATA_W-1:0]      reg_wdata;
  logic [`CL_DATA_W/8-1:0]    reg_wstrb;
  logic                       reg_ready;
  logic [`CL_DATA_W-1:0]      reg_rdata;
  logic                       reg_error;
  logic [2:0]                 mem_req;
  logic [2:0]                 mem_gnt;
  logic [2:0]                 mem_rvalid;
  logic [`CL_ADDR_W-1:0]      mem_addr [3];
  logic [`CL_ERR_W-1:0]       mem_err [3];
  logic [`CL_NUM_EXT_IRQ-1:0] irq_ext;
  logic [1:0]                 irq_timer;
  logic                       irq_ready;
  logic                       irq_valid;
  logic [`CL_IRQ_ID_W-1:0]    irq_id;
  logic [7:0]                 irq_level;
  logic [31:0]                stim [STIM_WORDS];
  logic [31:0]                rng_state;
  logic                       abort;
  int                         error_count;
  int                         test_errors;
  int                         tests_run;

  cl_periph_top u_dut (
    .clk_i (clk), .reset_i (reset),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_wstrb_i (reg_wstrb),
    .reg_ready_o (reg_ready), .reg_rdata_o (reg_rdata), .reg_error_o (reg_error),
    .instr_req_i (mem_req[0]), .instr_gnt_i (mem_gnt[0]), .instr_addr_i (mem_addr[0]),
    .instr_rvalid_i (mem_rvalid[0]), .instr_err_i (mem_err[0]),
    .data_req_i (mem_req[1]), .data_gnt_i (mem_gnt[1]), .data_addr_i (mem_addr[1]),
    .data_rvalid_i (mem_rvalid[1]), .data_err_i (mem_err[1]),
    .shadow_req_i (mem_req[2]), .shadow_gnt_i (mem_gnt[2]), .shadow_addr_i (mem_addr[2]),
    .shadow_rvalid_i (mem_rvalid[2]), .shadow_err_i (mem_err[2]),
    .irq_ext_i (irq_ext), .irq_timer_i (irq_timer), .irq_ready_i (irq_ready),
    .irq_valid_o (irq_valid), .irq_id_o (irq_id), .irq_level_o (irq_level)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  // Inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic reg_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waited;
    waited = 0;
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr  = addr;
    reg_wdata = wdata;
    next_cycle();
    // Every target answers one cycle after it sees valid
    check_value("reg_ready_o", 32'(reg_ready), 32'h1);
    while (!reg_ready && waited < REG_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!reg_ready) begin
      $display("register access to %h got no ready", addr);
      error_count++;
      test_errors++;
      abort = 1'b1;
    end
    rdata = reg_rdata;
    err   = reg_error;
    next_cycle();
    reg_valid = 1'b0;
  endtask

  task automatic drive_mem(input logic [1:0] bus, input logic req, input logic [31:0] addr,
                           input logic rvalid, input logic [1:0] err);
    mem_req[bus]    = req;
    mem_gnt[bus]    = req;
    mem_addr[bus]   = addr;
    mem_rvalid[bus] = rvalid;
    mem_err[bus]    = err;
  endtask

  task automatic mem_single(input logic [1:0] bus, input logic [31:0] addr,
                            input logic [1:0] err);
    drive_mem(bus, 1'b1, addr, 1'b0, 2'b0);
    next_cycle();
    drive_mem(bus, 1'b0, 32'h0, 1'b1, err);
    next_cycle();
    drive_mem(bus, 1'b0, 32'h0, 1'b0, 2'b0);
  endtask

  // Two grants before either response
  task automatic mem_pair(input logic [1:0] bus, input logic [31:0] a1, input logic [1:0] e1,
                          input logic [31:0] a2, input logic [1:0] e2);
    drive_mem(bus, 1'b1, a1, 1'b0, 2'b0);
    next_cycle();
    drive_mem(bus, 1'b1, a2, 1'b0, 2'b0);
    next_cycle();
    drive_mem(bus, 1'b0, 32'h0, 1'b1, e1);
    next_cycle();
    drive_mem(bus, 1'b0, 32'h0, 1'b1, e2);
    next_cycle();
    drive_mem(bus, 1'b0, 32'h0, 1'b0, 2'b0);
  endtask

  task automatic drain_queue(input logic [31:0] base, input logic [31:0] first,
                             input logic [31:0] code, input int count);
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < count; i++) begin
      reg_transfer(1'b0, base, 32'h0, rdata, err);
      check_value("reg_rdata_o", rdata, first + 32'(4 * i));
      reg_transfer(1'b0, base + 32'h4, 32'h0, rdata, err);
      check_value("reg_rdata_o", rdata, code);
      reg_transfer(1'b1, base + 32'h8, 32'h0, rdata, err);
    end
  endtask

  task automatic irq_expect(input logic exp_valid, input logic [5:0] exp_id,
                            input logic [7:0] exp_level);
    int waited;
    waited = 0;
    while ((irq_valid !== exp_valid || (exp_valid && irq_id !== exp_id)) &&
           waited < IRQ_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    check_value("irq_valid_o", 32'(irq_valid), 32'(exp_valid));
    if (exp_valid) begin
      check_value("irq_id_o", 32'(irq_id), 32'(exp_id));
      check_value("irq_level_o", 32'(irq_level), 32'(exp_level));
    end
  endtask

  // Valid is low for one cycle after the handshake, then back
  task automatic irq_ack(input logic [5:0] exp_id);
    int waited;
    waited = 0;
    while (!irq_valid && waited < IRQ_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!irq_valid) begin
      $display("no interrupt became valid to acknowledge");
      error_count++;
      test_errors++;
    end
    irq_ready = 1'b1;
    next_cycle();
    irq_ready = 1'b0;
    check_value("irq_valid_o", 32'(irq_valid), 32'h0);
    next_cycle();
    check_value("irq_valid_o", 32'(irq_valid), 32'h1);
    check_value("irq_id_o", 32'(irq_id), 32'(exp_id));
  endtask

  task automatic run_command(input logic [31:0] op, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] c,
                             input logic [31:0] d, input logic [31:0] e);
    logic [31:0] rdata;
    logic        err;
    case (op)
      32'h1: reg_transfer(1'b1, a, b, rdata, err);
      32'h2: begin
        reg_transfer(1'b0, a, 32'h0, rdata, err);
        check_value("reg_rdata_o", rdata, b);
        check_value("reg_error_o", {31'b0, err}, c);
      end
      32'h3: begin
        rng_state = xorshift(rng_state);
        reg_transfer(1'b1, a, rng_state, rdata, err);
      end
      32'h4: begin
        for (int i = 0; i < int'(d); i++) begin
          mem_single(a[1:0], b + 32'(4 * i), c[1:0]);
        end
      end
      32'h5: mem_pair(a[1:0], b, c[1:0], d, e[1:0]);
      32'h6: begin
        irq_ext   = a[15:0];
        irq_timer = b[1:0];
        next_cycle();
      end
      32'h7: irq_expect(a[0], b[5:0], c[7:0]);
      32'h8: irq_ack(a[5:0]);
      32'h9: drain_queue(a, b, c, int'(d));
      32'hE: begin
        $display("test %0d finished with %0d errors", a, test_errors);
        tests_run++;
        test_errors = 0;
      end
      default: begin
        $display("unknown stimulus command %h", op);
        error_count++;
        abort = 1'b1;
      end
    endcase
  endtask

  initial begin
    reset       = 1'b1;
    reg_valid   = 1'b0;
    reg_write   = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    reg_wstrb   = 4'hF;
    irq_ext     = '0;
    irq_timer   = '0;
    irq_ready   = 1'b0;
    rng_state   = 32'h3c0a;
    abort       = 1'b0;
    error_count = 0;
    test_errors = 0;
    tests_run   = 0;
    for (int b = 0; b < 3; b++) begin
      drive_mem(2'(b), 1'b0, 32'h0, 1'b0, 2'b0);
    end
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim[i] = '0;
    end
    $readmemh("sim/cl_periph_stimulus.txt", stim);
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    // A zero op marks the end of the commands
    for (int i = 0; i + 5 < STIM_WORDS; i += 6) begin
      if (abort || stim[i] == 32'h0) begin
        break;
      end
      run_command(stim[i], stim[i+1], stim[i+2], stim[i+3], stim[i+4], stim[i+5]);
    end
    if (tests_run == 0) begin
      $display("stimulus file ran no tests");
      error_count++;
    end
    $display("%0d tests run, %0d errors", tests_run, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
